/* logic/lsq_config.svh */
//////////////////////////////
// queue depths and field widths
//////////////////////////////

`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// queue depths
`define LSQ_LQ_DEPTH 4 // loads waiting on memory
`define LSQ_SQ_DEPTH 4 // stores waiting on commit

// field widths
`define LSQ_DATA_W 64 // data words and addresses
`define LSQ_TAG_W 6 // physical register tag
`define LSQ_ROB_W 5 // reorder buffer index

`endif

/* logic/lsq_pkg.sv */
//////////////////////////////
// lsq field and entry types
//////////////////////////////

package lsq_pkg;

`include "lsq_config.svh"

	//////////////////////////////
	// fields
	//////////////////////////////

	typedef logic [`LSQ_DATA_W-1:0] data_t; // word or address
	typedef logic [`LSQ_TAG_W-1:0] prf_tag_t; // dest register tag
	typedef logic [`LSQ_ROB_W-1:0] rob_idx_t; // rob slot

	//////////////////////////////
	// queue entries
	//////////////////////////////

	// load that missed the store queue, 70 bits
	typedef struct packed {
		data_t addr;
		prf_tag_t tag; // where the result goes
	} load_entry_t;

	// store held until the rob commits it, 133 bits
	typedef struct packed {
		data_t addr;
		data_t data;
		rob_idx_t rob_idx; // matched against commit index
	} store_entry_t;

endpackage

/* logic/lsq_queue_if.sv */
//////////////////////////////
// queue push side and contents
//////////////////////////////
`timescale 1ns/1ps

interface lsq_queue_if #(
	parameter type entry_t = logic,
	parameter int depth = 4
) ();

	// producer side
	logic push;
	entry_t push_entry;
	logic full;

	// consumer side
	entry_t head_entry;
	logic head_valid;
	logic pop;

	// contents oldest first, index 0 is the head
	entry_t entries [depth];
	logic [depth-1:0] valid;

	modport ring (input push, push_entry, pop,
		output full, head_entry, head_valid, entries, valid);

	modport producer (output push, push_entry,
		input full, entries, valid);

	modport consumer (input head_entry, head_valid,
		output pop);

endinterface

/* logic/lsq_ring.sv */
//////////////////////////////
// circular queue, age ordered view
//////////////////////////////
`timescale 1ns/1ps

module lsq_ring #(
	parameter type entry_t = logic,
	parameter int depth = 4
) (
	input logic clock,
	input logic reset,
	lsq_queue_if.ring q
);

	localparam int PW = $clog2(depth);
	localparam int CW = $clog2(depth + 1);
	localparam logic [PW-1:0] LAST_PTR = PW'(depth - 1);
	localparam logic [CW-1:0] FULL_COUNT = CW'(depth);

	entry_t mem [depth]; // payload only
	logic [PW-1:0] head, tail;
	logic [CW-1:0] count; // occupancy
	logic do_push, do_pop;

	// pointer step with wrap for any depth
	function automatic logic [PW-1:0] bump(input logic [PW-1:0] p);
		return (p == LAST_PTR) ? '0 : p + 1'b1;
	endfunction

	assign q.full = (count == FULL_COUNT);
	assign q.head_valid = (count != '0);
	assign q.head_entry = mem[head];

	assign do_push = q.push && !q.full; // never overwrite
	assign do_pop = q.pop && q.head_valid;

	// rotate so slot 0 is the oldest entry
	always_comb begin
		for (int i = 0; i < depth; i++) begin
			q.entries[i] = mem[(int'(head) + i) % depth];
			q.valid[i] = (i < int'(count));
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) tail <= bump(tail);
			if (do_pop) head <= bump(head);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) mem[tail] <= q.push_entry;
	end

endmodule

/* logic/lsq_dispatch.sv */
//////////////////////////////
// agen, store search, forwarding
//////////////////////////////
`timescale 1ns/1ps
`include "lsq_config.svh"

module lsq_dispatch (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input logic dispatch_is_store,
	input lsq_pkg::data_t dispatch_base,
	input lsq_pkg::data_t dispatch_offset,
	input lsq_pkg::data_t dispatch_store_data,
	input lsq_pkg::prf_tag_t dispatch_dest_tag,
	input lsq_pkg::rob_idx_t dispatch_rob_idx,
	output logic dispatch_ready,
	output logic cdb_fwd_valid,
	output lsq_pkg::prf_tag_t cdb_fwd_tag,
	output lsq_pkg::data_t cdb_fwd_data,
	lsq_queue_if.producer lq,
	lsq_queue_if.producer sq
);

	import lsq_pkg::*;

	logic accept;
	data_t addr; // base plus offset
	logic hit;
	data_t hit_data; // youngest matching store
	logic lq_push_q, sq_push_q; // push one cycle after accept
	load_entry_t lq_entry_q;
	store_entry_t sq_entry_q;
	logic lq_busy, sq_busy;

	// a push in flight counts as an entry already
	assign lq_busy = lq.full || (lq_push_q && lq.valid[`LSQ_LQ_DEPTH-2]);
	assign sq_busy = sq.full || (sq_push_q && sq.valid[`LSQ_SQ_DEPTH-2]);
	assign dispatch_ready = !lq_busy && !sq_busy;

	assign accept = dispatch_valid && dispatch_ready;
	assign addr = dispatch_base + dispatch_offset;

	//////////////////////////////
	// store queue search
	//////////////////////////////
	always_comb begin
		hit = 1'b0;
		hit_data = '0;
		// ascending age, so last match is youngest
		for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
			if (sq.valid[i] && (sq.entries[i].addr == addr)) begin
				hit = 1'b1;
				hit_data = sq.entries[i].data;
			end
		end
		// store still on its way into the ring is younger than all
		if (sq_push_q && (sq_entry_q.addr == addr)) begin
			hit = 1'b1;
			hit_data = sq_entry_q.data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lq_push_q <= 1'b0;
			sq_push_q <= 1'b0;
			cdb_fwd_valid <= 1'b0;
		end else begin
			lq_push_q <= accept && !dispatch_is_store && !hit; // miss
			sq_push_q <= accept && dispatch_is_store;
			cdb_fwd_valid <= accept && !dispatch_is_store && hit; // one cycle pulse
		end
	end

	// payload regs
	always_ff @(posedge clock) begin
		if (accept && !dispatch_is_store) begin
			lq_entry_q <= '{addr: addr, tag: dispatch_dest_tag};
			cdb_fwd_tag <= dispatch_dest_tag;
			cdb_fwd_data <= hit_data;
		end
		if (accept && dispatch_is_store)
			sq_entry_q <= '{addr: addr, data: dispatch_store_data, rob_idx: dispatch_rob_idx};
	end

	assign lq.push = lq_push_q;
	assign lq.push_entry = lq_entry_q;
	assign sq.push = sq_push_q;
	assign sq.push_entry = sq_entry_q;

endmodule

/* logic/lsq_mem_port.sv */
//////////////////////////////
// wishbone master, commit and loads
//////////////////////////////
`timescale 1ns/1ps

module lsq_mem_port (
	input logic clock,
	input logic reset,
	input logic commit_valid,
	input lsq_pkg::rob_idx_t commit_rob_idx,
	output logic commit_ready,
	lsq_queue_if.consumer lq,
	lsq_queue_if.consumer sq,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output lsq_pkg::data_t wb_adr,
	output lsq_pkg::data_t wb_dat_w,
	input lsq_pkg::data_t wb_dat_r,
	input logic wb_ack,
	output logic cdb_mem_valid,
	output lsq_pkg::prf_tag_t cdb_mem_tag,
	output lsq_pkg::data_t cdb_mem_data
);

	import lsq_pkg::*;

	typedef enum logic [1:0] {
		MP_IDLE,
		MP_STORE, // write of a committed store
		MP_LOAD // read for the load queue head
	} mp_state_t;

	mp_state_t state;
	logic commit_hit; // commit names the store at the head
	logic load_start;
	prf_tag_t ld_tag_q; // tag of load in flight

	//////////////////////////////
	// arbitration
	//////////////////////////////
	assign commit_hit = commit_valid && sq.head_valid
		&& (sq.head_entry.rob_idx == commit_rob_idx);

	// store write wins over a waiting load
	assign commit_ready = (state == MP_IDLE) && commit_hit;
	assign load_start = (state == MP_IDLE) && !commit_hit && lq.head_valid;

	assign sq.pop = commit_ready; // store leaves as its write starts
	assign lq.pop = (state == MP_LOAD) && wb_ack; // load leaves at the ack

	// bus control straight from state
	assign wb_cyc = (state != MP_IDLE);
	assign wb_stb = wb_cyc; // classic, one beat per cycle
	assign wb_we = (state == MP_STORE);

	//////////////////////////////
	// fsm
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= MP_IDLE;
			cdb_mem_valid <= 1'b0;
		end else begin
			cdb_mem_valid <= lq.pop; // cycle after ack
			case (state)
				MP_IDLE: begin
					if (commit_ready) state <= MP_STORE;
					else if (load_start) state <= MP_LOAD;
				end
				MP_STORE, MP_LOAD: begin
					if (wb_ack) state <= MP_IDLE; // free the bus
				end
				default: state <= MP_IDLE;
			endcase
		end
	end

	// address and data held for the whole cycle
	always_ff @(posedge clock) begin
		if (commit_ready) begin
			wb_adr <= sq.head_entry.addr;
			wb_dat_w <= sq.head_entry.data;
		end else if (load_start) begin
			wb_adr <= lq.head_entry.addr;
			ld_tag_q <= lq.head_entry.tag;
		end
	end

	// memory result regs
	always_ff @(posedge clock) begin
		if (lq.pop) begin
			cdb_mem_tag <= ld_tag_q;
			cdb_mem_data <= wb_dat_r; // read data comes with ack
		end
	end

endmodule

/* logic/lsq_top.sv */
//////////////////////////////
// load/store queue top level
//////////////////////////////
`timescale 1ns/1ps
`include "lsq_config.svh"

module lsq_top (
	input logic clock,
	input logic reset,
	// dispatch, one instruction per cycle
	input logic dispatch_valid,
	input logic dispatch_is_store,
	input lsq_pkg::data_t dispatch_base,
	input lsq_pkg::data_t dispatch_offset,
	input lsq_pkg::data_t dispatch_store_data,
	input lsq_pkg::prf_tag_t dispatch_dest_tag,
	input lsq_pkg::rob_idx_t dispatch_rob_idx,
	output logic dispatch_ready,
	// forwarded load results
	output logic cdb_fwd_valid,
	output lsq_pkg::prf_tag_t cdb_fwd_tag,
	output lsq_pkg::data_t cdb_fwd_data,
	// store commit from the rob
	input logic commit_valid,
	input lsq_pkg::rob_idx_t commit_rob_idx,
	output logic commit_ready,
	// wishbone master
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output lsq_pkg::data_t wb_adr,
	output lsq_pkg::data_t wb_dat_w,
	input lsq_pkg::data_t wb_dat_r,
	input logic wb_ack,
	// load results from memory
	output logic cdb_mem_valid,
	output lsq_pkg::prf_tag_t cdb_mem_tag,
	output lsq_pkg::data_t cdb_mem_data
);

	import lsq_pkg::*;

	lsq_queue_if #(.entry_t(load_entry_t), .depth(`LSQ_LQ_DEPTH)) lq_if ();
	lsq_queue_if #(.entry_t(store_entry_t), .depth(`LSQ_SQ_DEPTH)) sq_if ();

	lsq_ring #(.entry_t(load_entry_t), .depth(`LSQ_LQ_DEPTH)) u_lq_ring (
		.clock, .reset, .q(lq_if)
	);

	lsq_ring #(.entry_t(store_entry_t), .depth(`LSQ_SQ_DEPTH)) u_sq_ring (
		.clock, .reset, .q(sq_if)
	);

	lsq_dispatch u_dispatch (
		.clock, .reset,
		.dispatch_valid, .dispatch_is_store, .dispatch_base, .dispatch_offset,
		.dispatch_store_data, .dispatch_dest_tag, .dispatch_rob_idx, .dispatch_ready,
		.cdb_fwd_valid, .cdb_fwd_tag, .cdb_fwd_data,
		.lq(lq_if), .sq(sq_if)
	);

	lsq_mem_port u_mem_port (
		.clock, .reset,
		.commit_valid, .commit_rob_idx, .commit_ready,
		.lq(lq_if), .sq(sq_if),
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.cdb_mem_valid, .cdb_mem_tag, .cdb_mem_data
	);

endmodule

/* verification/lsq_properties.sv */
//////////////////////////////
// wishbone and result port assertions
//////////////////////////////
`timescale 1ns/1ps

module lsq_properties (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input logic dispatch_ready,
	input logic dispatch_is_store,
	input logic commit_ready,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input lsq_pkg::data_t wb_adr,
	input lsq_pkg::data_t wb_dat_w,
	input logic wb_ack,
	input logic cdb_fwd_valid,
	input logic cdb_mem_valid
);

	int assert_errors = 0; // failed assertions so far

	// strobe only inside a bus cycle
	stb_in_cyc: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
		else begin
			$error("wb_stb high without wb_cyc");
			assert_errors++;
		end

	// request held until the slave acks
	req_held: assert property (@(posedge clock) disable iff (reset)
		(wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_we) && $stable(wb_adr) && $stable(wb_dat_w)))
		else begin
			$error("wishbone request changed before ack");
			assert_errors++;
		end

	// one forward pulse per accepted load
	fwd_pulse: assert property (@(posedge clock) disable iff (reset)
		cdb_fwd_valid |-> $past(dispatch_valid && dispatch_ready && !dispatch_is_store))
		else begin
			$error("cdb_fwd_valid without a load accepted the cycle before");
			assert_errors++;
		end

	mem_pulse: assert property (@(posedge clock) disable iff (reset)
		cdb_mem_valid |=> !cdb_mem_valid)
		else begin
			$error("cdb_mem_valid longer than one cycle");
			assert_errors++;
		end

	// commit only starts on an idle bus
	commit_idle: assert property (@(posedge clock) disable iff (reset)
		commit_ready |-> !wb_cyc)
		else begin
			$error("commit_ready high during a bus cycle");
			assert_errors++;
		end

endmodule

bind lsq_top lsq_properties u_properties (.*);

/* verification/lsq_tb.sv */
//////////////////////////////
// lsq testbench, wishbone memory model
// reference model and checks
//////////////////////////////
`timescale 1ns/1ps
`include "lsq_config.svh"

module lsq_tb;

	import lsq_pkg::*;

	localparam int wait_limit = 2000; // cycles per wait loop
	localparam data_t addr_base = 64'h0000_0000_0000_1000;

	typedef struct packed {
		data_t addr;
		data_t data;
		rob_idx_t rob_idx;
		logic [31:0] mem_before; // missed loads dispatched ahead of it
	} tb_store_t;

	typedef struct packed {
		prf_tag_t tag;
		data_t data;
	} tb_load_t;

	logic clock;
	logic reset = 1'b1;
	logic dispatch_valid, dispatch_is_store, dispatch_ready;
	data_t dispatch_base, dispatch_offset, dispatch_store_data;
	prf_tag_t dispatch_dest_tag;
	rob_idx_t dispatch_rob_idx;
	logic cdb_fwd_valid, cdb_mem_valid;
	prf_tag_t cdb_fwd_tag, cdb_mem_tag;
	data_t cdb_fwd_data, cdb_mem_data;
	logic commit_valid, commit_ready;
	rob_idx_t commit_rob_idx;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	data_t wb_adr, wb_dat_w, wb_dat_r;

	int seed = 32'hdf53_f1e8;
	int bus_seed = 32'hdf53_f1e8 + 1; // own stream for ack delays
	int errors = 0;
	int failures = 0; // timeouts and protocol slips
	int loads_sent = 0, loads_done = 0, stores_sent = 0, writes_seen = 0;
	int mem_loads_sent = 0, mem_returned = 0;
	int ack_wait;
	logic hold_commits = 1'b0;
	rob_idx_t rob_next = '0;

	tb_store_t pend[$]; // dispatched and not yet committed, in program order
	tb_store_t wr_expect[$]; // committed with write not yet acked
	tb_load_t exp_fwd[$];
	tb_load_t exp_mem[$];
	data_t model_mem [data_t]; // reference memory, acked writes
	data_t wb_mem [data_t]; // slave side storage

	lsq_top uut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic check_value(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("failure at %0t: %s", $time, what);
	endtask

	// pattern for unwritten words uses every address bit
	function automatic data_t fill_word(input data_t addr);
		return {addr[31:0], addr[63:32]} ^ 64'hc3c3_5a5a_a5a5_3c3c;
	endfunction

	// value a missing load must see
	function automatic data_t memory_value(input data_t addr);
		data_t v;
		v = model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
		foreach (wr_expect[i])
			if (wr_expect[i].addr == addr) v = wr_expect[i].data; // committed but not yet acked
		return v;
	endfunction

	function automatic int outstanding();
		return pend.size() + wr_expect.size() + exp_mem.size() + exp_fwd.size();
	endfunction

	// one instruction held until accepted
	task automatic dispatch_one(input logic is_store);
		int t;
		data_t target;
		target = addr_base + data_t'(($random(seed) & 7) * 8); // 8 words only
		dispatch_valid = 1'b1;
		dispatch_is_store = is_store;
		dispatch_base = {$random(seed), $random(seed)};
		dispatch_offset = target - dispatch_base; // agen lands on target
		dispatch_store_data = {$random(seed), $random(seed)};
		dispatch_dest_tag = prf_tag_t'($random(seed));
		dispatch_rob_idx = rob_next;
		if (is_store) rob_next++;
		t = 0;
		@(posedge clock);
		while (!dispatch_ready && t < wait_limit) begin
			@(posedge clock);
			t++;
		end
		if (!dispatch_ready) report_failure("dispatch was never accepted");
		#1;
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_commit();
		int t;
		t = 0;
		@(posedge clock);
		while (!commit_ready && t < wait_limit) begin
			@(posedge clock);
			t++;
		end
		if (!commit_ready) report_failure("commit_ready never came for the head store");
		#1;
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (outstanding() > 0 && t < wait_limit) begin
			@(posedge clock);
			t++;
		end
		if (outstanding() > 0) report_failure("queues did not drain");
		@(posedge clock);
		#1;
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			errors, failures, uut.u_properties.assert_errors);
		if (errors == 0 && failures == 0 && uut.u_properties.assert_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	//////////////////////////////
	// environment
	//////////////////////////////
	// rob side commits once older loads are back
	initial begin
		commit_valid = 1'b0;
		commit_rob_idx = '0;
		forever begin
			@(posedge clock);
			#1;
			if (!reset && !hold_commits && pend.size() > 0
				&& mem_returned >= pend[0].mem_before) begin
				commit_valid = 1'b1;
				commit_rob_idx = pend[0].rob_idx;
				wait_commit();
				commit_valid = 1'b0;
			end
		end
	end

	// wishbone slave with 0 to 3 wait cycles
	initial begin
		wb_ack = 1'b0;
		wb_dat_r = '0;
		ack_wait = 0;
		forever begin
			@(posedge clock);
			#1;
			if (reset || wb_ack) begin
				wb_ack = 1'b0; // single beat then master drops cyc
				ack_wait = $random(bus_seed) & 3;
			end else if (wb_cyc && wb_stb) begin
				if (ack_wait > 0) begin
					ack_wait--;
				end else begin
					wb_ack = 1'b1;
					if (wb_we) wb_mem[wb_adr] = wb_dat_w;
					else wb_dat_r = wb_mem.exists(wb_adr) ? wb_mem[wb_adr] : fill_word(wb_adr);
				end
			end
		end
	end

	//////////////////////////////
	// reference model and checks
	//////////////////////////////
	always @(posedge clock) begin
		tb_store_t st;
		tb_load_t ld;
		data_t addr;
		logic hit;
		if (!reset) begin
			// forward due exactly one cycle after its load
			if (exp_fwd.size() > 0) begin
				ld = exp_fwd.pop_front();
				check_value("cdb_fwd_valid", data_t'(cdb_fwd_valid), 64'd1);
				check_value("cdb_fwd_tag", data_t'(cdb_fwd_tag), data_t'(ld.tag));
				check_value("cdb_fwd_data", cdb_fwd_data, ld.data);
				loads_done++;
			end else if (cdb_fwd_valid) begin
				report_failure("forwarded result with no load behind it");
			end
			if (cdb_mem_valid) begin
				if (exp_mem.size() == 0) begin
					report_failure("memory result with no load waiting");
				end else begin
					ld = exp_mem.pop_front(); // dispatch order
					check_value("cdb_mem_tag", data_t'(cdb_mem_tag), data_t'(ld.tag));
					check_value("cdb_mem_data", cdb_mem_data, ld.data);
					mem_returned++;
					loads_done++;
				end
			end
			if (wb_cyc && wb_stb && wb_ack && wb_we) begin
				if (wr_expect.size() == 0) begin
					report_failure("bus write with no committed store");
				end else begin
					st = wr_expect.pop_front();
					check_value("wb_adr", wb_adr, st.addr);
					check_value("wb_dat_w", wb_dat_w, st.data);
					model_mem[st.addr] = st.data;
					writes_seen++;
				end
			end
			// search before commit so a store leaving this cycle still forwards
			if (dispatch_valid && dispatch_ready) begin
				addr = dispatch_base + dispatch_offset;
				if (dispatch_is_store) begin
					st = '{addr: addr, data: dispatch_store_data,
						rob_idx: dispatch_rob_idx, mem_before: mem_loads_sent};
					pend.push_back(st);
					stores_sent++;
				end else begin
					hit = 1'b0;
					ld = '{tag: dispatch_dest_tag, data: '0};
					foreach (pend[i]) begin
						if (pend[i].addr == addr) begin
							hit = 1'b1;
							ld.data = pend[i].data; // youngest wins
						end
					end
					if (hit) begin
						exp_fwd.push_back(ld);
					end else begin
						ld.data = memory_value(addr);
						exp_mem.push_back(ld);
						mem_loads_sent++;
					end
					loads_sent++;
				end
			end
			if (commit_valid && commit_ready) begin
				if (pend.size() == 0) begin
					report_failure("commit accepted with no store pending");
				end else begin
					st = pend.pop_front();
					wr_expect.push_back(st);
				end
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		dispatch_valid = 1'b0;
		dispatch_is_store = 1'b0;
		dispatch_base = '0;
		dispatch_offset = '0;
		dispatch_store_data = '0;
		dispatch_dest_tag = '0;
		dispatch_rob_idx = '0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock);
		check_value("cdb_fwd_valid", data_t'(cdb_fwd_valid), 64'd0);
		check_value("cdb_mem_valid", data_t'(cdb_mem_valid), 64'd0);
		check_value("wb_cyc", data_t'(wb_cyc), 64'd0);
		check_value("wb_stb", data_t'(wb_stb), 64'd0);
		check_value("commit_ready", data_t'(commit_ready), 64'd0);
		check_value("dispatch_ready", data_t'(dispatch_ready), 64'd1);
		#1;
		// random mix with about 3 in 8 stores
		for (int n = 0; n < 400; n++) begin
			repeat ($random(seed) & 1) begin
				@(posedge clock);
				#1;
			end
			dispatch_one(($random(seed) & 7) < 3);
		end
		drain();
		// fill the store queue with commits held back
		@(posedge clock);
		hold_commits = 1'b1;
		#1;
		for (int n = 0; n < `LSQ_SQ_DEPTH; n++)
			dispatch_one(1'b1);
		repeat (3) begin
			@(posedge clock);
			check_value("dispatch_ready", data_t'(dispatch_ready), 64'd0);
		end
		hold_commits = 1'b0; // commit driver picks this up at +1
		#1;
		for (int n = 0; n < 20; n++)
			dispatch_one(($random(seed) & 1) == 0);
		drain();
		check_value("load results", data_t'(loads_done), data_t'(loads_sent));
		check_value("store writes", data_t'(writes_seen), data_t'(stores_sent));
		finish_run();
	end

endmodule

/* files.f */
+incdir+logic
logic/lsq_pkg.sv
logic/lsq_queue_if.sv
logic/lsq_ring.sv
logic/lsq_dispatch.sv
logic/lsq_mem_port.sv
logic/lsq_top.sv
verification/lsq_properties.sv
verification/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsq_pkg.sv
      - logic/lsq_queue_if.sv
      - logic/lsq_ring.sv
      - logic/lsq_dispatch.sv
      - logic/lsq_mem_port.sv
      - logic/lsq_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/lsq_properties.sv
      - verification/lsq_tb.sv
